/* all.f */
+incdir+hdl
hdl/ext_pkg.sv
hdl/memcopy_periph.sv
hdl/obi_arbiter.sv
hdl/slow_memory.sv
hdl/ext_subsys_top.sv
tests/tb_clk_gen.sv
tests/tb_ext_subsys.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_ext_subsys
FILELIST   := all.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_ext_subsys.sv */
/*
 * Directed tests for the external subsystem: register and OBI driver
 * tasks, compare tasks, byte-merging RAM model, timeout and summary
 */
`timescale 1ns/1ps
`include "ext_macros.svh"

module tb_ext_subsys;

  // 64 words x about 20 cycles per word x 6 tests, with margin
  localparam int timeout_cycles = 20000;
  localparam int bus_wait_max   = 100;
  localparam int intr_wait_max  = 2000;

  localparam logic [31:0] src_reg    = {24'd0, `MEMCOPY_SRC_OFS};
  localparam logic [31:0] dst_reg    = {24'd0, `MEMCOPY_DST_OFS};
  localparam logic [31:0] size_reg   = {24'd0, `MEMCOPY_SIZE_OFS};
  localparam logic [31:0] status_reg = {24'd0, `MEMCOPY_STATUS_OFS};

  logic               clk;
  logic               rst;
  logic               intr;
  ext_pkg::reg_req_t  reg_req;
  ext_pkg::reg_rsp_t  reg_rsp;
  ext_pkg::obi_req_t  slv_req;
  ext_pkg::obi_resp_t slv_resp;

  // Expected RAM contents, one entry per word
  logic [31:0] model [`EXT_MEM_WORDS];

  integer seed;
  int     errors;
  int     mark;
  int     tests_passed;
  int     tests_failed;
  int     cycles = 0;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  ext_subsys_top dut0 (
    .clk_i          (clk),
    .rst_i          (rst),
    .reg_req_i      (reg_req),
    .reg_rsp_o      (reg_rsp),
    .slv_req_i      (slv_req),
    .slv_resp_o     (slv_resp),
    .memcopy_intr_o (intr)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("Run stopped: still not finished after %0d cycles", timeout_cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] word_addr(input int idx);
    return 32'(idx) << 2;
  endfunction

  // Only the bytes selected by be take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic check_reg_rsp(input string name, input ext_pkg::reg_rsp_t exp,
                               input ext_pkg::reg_rsp_t act, input bit cmp_data);
    if (act.ready !== exp.ready || act.error !== exp.error ||
        (cmp_data && act.rdata !== exp.rdata)) begin
      errors++;
      $display("CHECK FAILED %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_obi_data(input string name, input logic [31:0] exp,
                                input ext_pkg::obi_resp_t act);
    if (act.rdata !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %h got %h", name, exp, act.rdata);
    end
  endtask

  task automatic check_intr(input logic exp);
    if (intr !== exp) begin
      errors++;
      $display("CHECK FAILED memcopy_intr_o expected %h got %h", exp, intr);
    end
  endtask

  task automatic check_obi_idle(input ext_pkg::obi_resp_t act);
    if (act.gnt !== 1'b0 || act.rvalid !== 1'b0) begin
      errors++;
      $display("CHECK FAILED slv_resp_o gnt/rvalid expected 0/0 got %h/%h", act.gnt, act.rvalid);
    end
  endtask

  // Entered and left 2 ns after a rising edge; the transfer is on the next edge
  task automatic reg_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output ext_pkg::reg_rsp_t rsp);
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    @(negedge clk);
    rsp = reg_rsp;
    @(posedge clk);
    #2;
    reg_req = '0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic exp_error);
    ext_pkg::reg_rsp_t rsp;
    ext_pkg::reg_rsp_t exp;
    exp = '{ready: 1'b1, error: exp_error, rdata: 32'd0};
    reg_access(1'b1, addr, wdata, rsp);
    check_reg_rsp("reg_rsp_o", exp, rsp, 1'b0);
  endtask

  task automatic reg_read(input logic [31:0] addr, input logic [31:0] exp_data,
                          input logic exp_error);
    ext_pkg::reg_rsp_t rsp;
    ext_pkg::reg_rsp_t exp;
    exp = '{ready: 1'b1, error: exp_error, rdata: exp_data};
    reg_access(1'b0, addr, 32'd0, rsp);
    check_reg_rsp("reg_rsp_o", exp, rsp, 1'b1);
  endtask

  // Request held until gnt, then wait for rvalid
  task automatic obi_transfer(input logic we, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata, output ext_pkg::obi_resp_t resp);
    int   waited;
    logic granted;
    slv_req = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    waited  = 0;
    granted = 1'b0;
    resp    = '0;
    while (!granted && waited < bus_wait_max) begin
      @(negedge clk);
      granted = slv_resp.gnt;
      @(posedge clk);
      #2;
      waited++;
    end
    slv_req = '0;
    if (!granted) begin
      errors++;
      $display("No grant on the system port for address %h", addr);
    end else begin
      waited = 0;
      while (!resp.rvalid && waited < bus_wait_max) begin
        @(negedge clk);
        resp = slv_resp;
        @(posedge clk);
        #2;
        waited++;
      end
      if (!resp.rvalid) begin
        errors++;
        $display("No rvalid on the system port for address %h", addr);
      end
    end
  endtask

  task automatic obi_write(input int idx, input logic [3:0] be, input logic [31:0] wdata);
    ext_pkg::obi_resp_t resp;
    obi_transfer(1'b1, be, word_addr(idx), wdata, resp);
    model[idx] = merge_bytes(model[idx], wdata, be);
  endtask

  task automatic obi_read(input int idx);
    ext_pkg::obi_resp_t resp;
    obi_transfer(1'b0, 4'hF, word_addr(idx), 32'd0, resp);
    check_obi_data("slv_resp_o.rdata", model[idx], resp);
  endtask

  task automatic wait_for_intr();
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < intr_wait_max) begin
      @(negedge clk);
      seen = intr;
      @(posedge clk);
      #2;
      waited++;
    end
    if (!seen) begin
      errors++;
      $display("The copy interrupt did not arrive within %0d cycles", intr_wait_max);
    end else begin
      // Pulse must be gone in the next cycle
      @(negedge clk);
      check_intr(1'b0);
      @(posedge clk);
      #2;
    end
  endtask

  task automatic preload(input int idx, input int n);
    for (int i = 0; i < n; i++) begin
      obi_write(idx + i, 4'hF, $random(seed));
    end
  endtask

  task automatic start_copy(input int src_idx, input int dst_idx, input int n);
    reg_write(src_reg, word_addr(src_idx), 1'b0);
    reg_write(dst_reg, word_addr(dst_idx), 1'b0);
    reg_write(size_reg, 32'(n), 1'b0);
    for (int i = 0; i < n; i++) begin
      model[dst_idx + i] = model[src_idx + i];
    end
  endtask

  task automatic verify(input int idx, input int n);
    for (int i = 0; i < n; i++) begin
      obi_read(idx + i);
    end
  endtask

  task automatic test_reset();
    reg_read(status_reg, 32'd1, 1'b0);
    check_intr(1'b0);
    check_obi_idle(slv_resp);
  endtask

  task automatic test_sys_access();
    preload(0, 8);
    for (int i = 0; i < 8; i++) begin
      obi_write(i, 4'($random(seed)), $random(seed));
    end
    verify(0, 8);
  endtask

  task automatic test_registers();
    reg_write(src_reg, 32'h0000_0040, 1'b0);
    reg_write(dst_reg, 32'h0000_00C0, 1'b0);
    reg_read(src_reg, 32'h0000_0040, 1'b0);
    reg_read(dst_reg, 32'h0000_00C0, 1'b0);
    reg_read(32'h0000_0010, 32'd0, 1'b1);
  endtask

  task automatic test_directed_copy();
    preload(16, 8);
    start_copy(16, 48, 8);
    wait_for_intr();
    reg_read(status_reg, 32'd1, 1'b0);
    verify(48, 8);
  endtask

  task automatic test_contention();
    preload(64, 16);
    start_copy(64, 96, 16);
    // Engine is busy now
    reg_write(size_reg, 32'd4, 1'b1);
    reg_read(status_reg, 32'd0, 1'b0);
    obi_read(5);
    wait_for_intr();
    reg_read(status_reg, 32'd1, 1'b0);
    verify(96, 16);
  endtask

  task automatic test_random_copies();
    int n;
    int src_idx;
    int dst_idx;
    for (int c = 0; c < 4; c++) begin
      n = $unsigned($random(seed)) % 33;
      // Source in the lower half, destination in the upper half
      src_idx = $unsigned($random(seed)) % (65 - n);
      dst_idx = 64 + $unsigned($random(seed)) % (65 - n);
      preload(src_idx, n);
      start_copy(src_idx, dst_idx, n);
      wait_for_intr();
      verify(dst_idx, n);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    reg_req      = '0;
    slv_req      = '0;
    seed         = 3;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    @(negedge rst);
    @(posedge clk);
    #2;
    mark = errors;
    test_reset();
    finish_test("reset state", mark);
    mark = errors;
    test_sys_access();
    finish_test("system port access", mark);
    mark = errors;
    test_registers();
    finish_test("registers", mark);
    mark = errors;
    test_directed_copy();
    finish_test("directed copy", mark);
    mark = errors;
    test_contention();
    finish_test("contention", mark);
    mark = errors;
    test_random_copies();
    finish_test("random copies", mark);
    $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* tests/tb_clk_gen.sv */
/*
 * Testbench clock (20 ns period) and reset for 3 cycles
 */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Released just after the third rising edge
  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #2 rst_o = 1'b0;
  end

endmodule

/* hdl/ext_subsys_top.sv */
/*
 * External subsystem: memcopy peripheral and system port
 * sharing the slow RAM through an OBI arbiter
 */
`timescale 1ns/1ps

module ext_subsys_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  ext_pkg::reg_req_t   reg_req_i,
  output ext_pkg::reg_rsp_t   reg_rsp_o,
  input  ext_pkg::obi_req_t   slv_req_i,
  output ext_pkg::obi_resp_t  slv_resp_o,
  output logic                memcopy_intr_o
);

  // Memcopy master port
  ext_pkg::obi_req_t  dma_req;
  ext_pkg::obi_resp_t dma_resp;

  // Arbiter to RAM
  ext_pkg::obi_req_t  ram_req;
  ext_pkg::obi_resp_t ram_resp;

  memcopy_periph u_memcopy (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .reg_req_i      (reg_req_i),
    .reg_rsp_o      (reg_rsp_o),
    .master_req_o   (dma_req),
    .master_resp_i  (dma_resp),
    .memcopy_intr_o (memcopy_intr_o)
  );

  obi_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .m0_req_i  (slv_req_i),
    .m1_req_i  (dma_req),
    .m0_resp_o (slv_resp_o),
    .m1_resp_o (dma_resp),
    .s_req_o   (ram_req),
    .s_resp_i  (ram_resp)
  );

  slow_memory u_slow_ram (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .req_i  (ram_req),
    .resp_o (ram_resp)
  );

endmodule

/* hdl/slow_memory.sv */
/*
 * Single-port RAM behind OBI with LFSR-driven
 * grant and response wait states
 */
`timescale 1ns/1ps
`include "ext_macros.svh"

module slow_memory #(
  parameter int NumWords = `EXT_MEM_WORDS
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  ext_pkg::obi_req_t   req_i,
  output ext_pkg::obi_resp_t  resp_o
);

  localparam int AddrW  = $clog2(NumWords);
  localparam int NBytes = `EXT_DATA_W / 8;

  logic [`EXT_DATA_W-1:0] mem [NumWords];

  logic [7:0]             lfsr_q;
  logic [1:0]             gcnt_q;
  logic [1:0]             gtarget_q;
  logic [1:0]             gtarget;
  logic [1:0]             rcnt_q;
  logic                   pending_q;
  logic [`EXT_DATA_W-1:0] rdata_q;
  logic [AddrW-1:0]       waddr;
  logic                   gnt;

  assign waddr = req_i.addr[AddrW+1:2];

  // Wait target is drawn from the LFSR in the first cycle of a request
  assign gtarget = (gcnt_q == 2'd0) ? lfsr_q[1:0] : gtarget_q;
  assign gnt     = req_i.req && !pending_q && (gcnt_q == gtarget);

  assign resp_o.gnt    = gnt;
  assign resp_o.rvalid = pending_q && (rcnt_q == 2'd0);
  assign resp_o.rdata  = rdata_q;

  // Free-running LFSR, x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q <= 8'hA5;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  // Grant wait and response wait counters
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gcnt_q    <= '0;
      gtarget_q <= '0;
      rcnt_q    <= '0;
      pending_q <= 1'b0;
    end else begin
      if (gnt || !req_i.req) begin
        gcnt_q <= '0;
      end else if (!pending_q) begin
        gcnt_q <= gcnt_q + 2'd1;
        if (gcnt_q == 2'd0) gtarget_q <= lfsr_q[1:0];
      end

      if (gnt) begin
        pending_q <= 1'b1;
        // 0 to 3 extra cycles, so rvalid lands 1 to 4 after gnt
        rcnt_q    <= lfsr_q[3:2];
      end else if (pending_q) begin
        if (rcnt_q == 2'd0) begin
          pending_q <= 1'b0;
        end else begin
          rcnt_q <= rcnt_q - 2'd1;
        end
      end
    end
  end

  // RAM access at grant, byte-enabled writes
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (req_i.we) begin
        for (int b = 0; b < NBytes; b++) begin
          if (req_i.be[b]) mem[waddr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end else begin
        rdata_q <= mem[waddr];
      end
    end
  end

  // Every grant gets its response within the wait window
  a_rsp_window: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_o.gnt |-> ##[1:4] resp_o.rvalid);

endmodule

/* hdl/obi_arbiter.sv */
/*
 * Two-master, one-slave round-robin OBI arbiter,
 * route held from first request until rvalid
 */
`timescale 1ns/1ps

module obi_arbiter (
  input  logic                clk_i,
  input  logic                rst_i,
  input  ext_pkg::obi_req_t   m0_req_i,
  input  ext_pkg::obi_req_t   m1_req_i,
  output ext_pkg::obi_resp_t  m0_resp_o,
  output ext_pkg::obi_resp_t  m1_resp_o,
  output ext_pkg::obi_req_t   s_req_o,
  input  ext_pkg::obi_resp_t  s_resp_i
);

  logic prio_q;
  logic lock_q;
  logic wait_q;
  logic owner_q;
  logic sel;

  // Keep the owner while locked or while its request waits for gnt
  always_comb begin
    if (lock_q || wait_q) begin
      sel = owner_q;
    end else if (m0_req_i.req && m1_req_i.req) begin
      sel = prio_q;
    end else begin
      sel = m1_req_i.req;
    end
  end

  assign s_req_o = sel ? m1_req_i : m0_req_i;

  always_comb begin
    m0_resp_o        = s_resp_i;
    m1_resp_o        = s_resp_i;
    m0_resp_o.gnt    = s_resp_i.gnt && !sel;
    m0_resp_o.rvalid = s_resp_i.rvalid && !sel;
    m1_resp_o.gnt    = s_resp_i.gnt && sel;
    m1_resp_o.rvalid = s_resp_i.rvalid && sel;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q  <= 1'b0;
      lock_q  <= 1'b0;
      wait_q  <= 1'b0;
      owner_q <= 1'b0;
    end else begin
      owner_q <= sel;
      wait_q  <= s_req_o.req && !s_resp_i.gnt;
      if (s_resp_i.rvalid) begin
        lock_q <= 1'b0;
      end else if (s_resp_i.gnt) begin
        lock_q <= 1'b1;
      end
      // The other master goes first next time
      if (s_resp_i.gnt) begin
        prio_q <= ~sel;
      end
    end
  end

  // No grant to either master while a response is still outstanding
  a_one_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    lock_q |-> !(m0_resp_o.gnt || m1_resp_o.gnt));

endmodule

/* hdl/memcopy_periph.sv */
/*
 * Memcopy peripheral: SRC/DST/SIZE/STATUS registers and
 * a word-by-word copy engine on an OBI master port
 */
`timescale 1ns/1ps
`include "ext_macros.svh"

module memcopy_periph (
  input  logic                clk_i,
  input  logic                rst_i,
  input  ext_pkg::reg_req_t   reg_req_i,
  output ext_pkg::reg_rsp_t   reg_rsp_o,
  output ext_pkg::obi_req_t   master_req_o,
  input  ext_pkg::obi_resp_t  master_resp_i,
  output logic                memcopy_intr_o
);

  ext_pkg::copy_state_e state_q;

  logic [31:0]            src_q;
  logic [31:0]            dst_q;
  logic [31:0]            size_q;
  logic [31:0]            rem_q;
  logic [31:0]            rd_ptr_q;
  logic [31:0]            wr_ptr_q;
  logic [`EXT_DATA_W-1:0] data_q;

  logic [7:0] reg_ofs;
  logic       idle;
  logic       reg_wr;
  logic       start;

  assign reg_ofs = reg_req_i.addr[7:0];
  assign idle    = (state_q == ext_pkg::IDLE);
  assign reg_wr  = reg_req_i.valid && reg_req_i.write;
  // A SIZE write only starts a copy when the engine is idle
  assign start   = reg_wr && (reg_ofs == `MEMCOPY_SIZE_OFS) && idle;

  // Register read data and error, combinational from the registers
  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    case (reg_ofs)
      `MEMCOPY_SRC_OFS: begin
        reg_rsp_o.rdata = src_q;
      end
      `MEMCOPY_DST_OFS: begin
        reg_rsp_o.rdata = dst_q;
      end
      `MEMCOPY_SIZE_OFS: begin
        reg_rsp_o.rdata = size_q;
        reg_rsp_o.error = reg_wr && !idle;
      end
      `MEMCOPY_STATUS_OFS: begin
        reg_rsp_o.rdata = {31'd0, idle};
      end
      default: begin
        reg_rsp_o.error = reg_req_i.valid;
      end
    endcase
  end

  // Configuration registers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      src_q  <= '0;
      dst_q  <= '0;
      size_q <= '0;
    end else if (reg_wr) begin
      case (reg_ofs)
        `MEMCOPY_SRC_OFS: src_q <= reg_req_i.wdata;
        `MEMCOPY_DST_OFS: dst_q <= reg_req_i.wdata;
        `MEMCOPY_SIZE_OFS: begin
          if (idle) begin
            size_q <= reg_req_i.wdata;
          end
        end
        default: ;
      endcase
    end
  end

  // Copy FSM, one read then one write per word
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ext_pkg::IDLE;
      rem_q   <= '0;
    end else begin
      case (state_q)
        ext_pkg::IDLE: begin
          if (start) begin
            rem_q   <= reg_req_i.wdata;
            // Zero words goes straight to the interrupt
            state_q <= (reg_req_i.wdata == '0) ? ext_pkg::DONE : ext_pkg::RD_REQ;
          end
        end
        ext_pkg::RD_REQ: begin
          if (master_resp_i.gnt) state_q <= ext_pkg::RD_WAIT;
        end
        ext_pkg::RD_WAIT: begin
          if (master_resp_i.rvalid) state_q <= ext_pkg::WR_REQ;
        end
        ext_pkg::WR_REQ: begin
          if (master_resp_i.gnt) state_q <= ext_pkg::WR_WAIT;
        end
        ext_pkg::WR_WAIT: begin
          if (master_resp_i.rvalid) begin
            if (rem_q == 32'd1) begin
              state_q <= ext_pkg::DONE;
            end else begin
              state_q <= ext_pkg::RD_REQ;
            end
            rem_q <= rem_q - 32'd1;
          end
        end
        ext_pkg::DONE: begin
          state_q <= ext_pkg::IDLE;
        end
        default: state_q <= ext_pkg::IDLE;
      endcase
    end
  end

  // Working pointers and the word in flight
  always_ff @(posedge clk_i) begin
    if (start) begin
      rd_ptr_q <= src_q;
      wr_ptr_q <= dst_q;
    end else if (state_q == ext_pkg::WR_WAIT && master_resp_i.rvalid) begin
      rd_ptr_q <= rd_ptr_q + 32'd4;
      wr_ptr_q <= wr_ptr_q + 32'd4;
    end
    if (state_q == ext_pkg::RD_WAIT && master_resp_i.rvalid) begin
      data_q <= master_resp_i.rdata;
    end
  end

  // OBI master request, full words only
  always_comb begin
    master_req_o.req   = (state_q == ext_pkg::RD_REQ) || (state_q == ext_pkg::WR_REQ);
    master_req_o.we    = (state_q == ext_pkg::WR_REQ);
    master_req_o.be    = '1;
    master_req_o.addr  = (state_q == ext_pkg::WR_REQ) ? wr_ptr_q : rd_ptr_q;
    master_req_o.wdata = data_q;
  end

  assign memcopy_intr_o = (state_q == ext_pkg::DONE);

  // Request held until accepted
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    master_req_o.req && !master_resp_i.gnt |=> $stable(master_req_o));

  // Interrupt is a single-cycle pulse
  a_intr_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    memcopy_intr_o |=> !memcopy_intr_o);

endmodule

/* hdl/ext_pkg.sv */
/*
 * Register-port and OBI request/response structs,
 * copy-engine state type
 */
`include "ext_macros.svh"

package ext_pkg;

  // Register port request, one transfer per cycle with valid high
  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [31:0]            addr;
    logic [`EXT_DATA_W-1:0] wdata;
  } reg_req_t;

  // Register port response, same cycle as the request
  typedef struct packed {
    logic                   ready;
    logic                   error;
    logic [`EXT_DATA_W-1:0] rdata;
  } reg_rsp_t;

  // OBI request, held stable until gnt
  typedef struct packed {
    logic                     req;
    logic                     we;
    logic [`EXT_DATA_W/8-1:0] be;
    logic [31:0]              addr;
    logic [`EXT_DATA_W-1:0]   wdata;
  } obi_req_t;

  // OBI response
  typedef struct packed {
    logic                   gnt;
    logic                   rvalid;
    logic [`EXT_DATA_W-1:0] rdata;
  } obi_resp_t;

  // Copy engine states
  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    WR_WAIT,
    DONE
  } copy_state_e;

endpackage

/* hdl/ext_macros.svh */
/*
 * Bus width, RAM depth and memcopy register offsets
 */
`ifndef EXT_MACROS_SVH
`define EXT_MACROS_SVH

// Bus data width in bits
`define EXT_DATA_W 32

// Slow RAM depth in words, word address bits 8 to 2
`define EXT_MEM_WORDS 128

// Memcopy register byte offsets
`define MEMCOPY_SRC_OFS    8'h00
`define MEMCOPY_DST_OFS    8'h04
`define MEMCOPY_SIZE_OFS   8'h08
`define MEMCOPY_STATUS_OFS 8'h0C

`endif
